// File: gshare_predictor.f
+incdir+source
+incdir+tb
source/gshare_pkg.sv
source/history_reg.sv
source/pattern_table.sv
source/target_buffer.sv
source/fetch_steer_ctrl.sv
source/gshare_predictor.sv
tb/gshare_tb.sv

// File: source/fetch_steer_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_steer_ctrl import gshare_pkg::*; (
    input  wire lookup_t  lookup_i,
    input  wire resolve_t resolve_i,
    input  wire logic     btb_hit_i,
    input  wire pc_t      btb_target_i,
    input  wire logic     pht_taken_i,
    input  wire hist_t    ghr_i,

    output pred_t         pred_o,
    output pc_t           next_pc_o,
    output logic          flush_o,
    output logic          hist_we_o,
    output logic          pht_we_o,
    output logic          btb_we_o
);

    logic         mispredict;
    logic         pred_taken;
    next_pc_src_e next_src;
    pc_t          lookup_seq_pc;
    pc_t          resolve_seq_pc;

    // Outcome disagrees with what fetch acted on
    assign mispredict = resolve_i.valid && (resolve_i.taken != resolve_i.pred_taken);
    assign flush_o    = mispredict;

    // Every resolved transfer trains direction and history
    assign hist_we_o = resolve_i.valid;
    assign pht_we_o  = resolve_i.valid;

    // Only taken transfers earn a BTB entry
    assign btb_we_o = resolve_i.valid && resolve_i.taken;

    // Without a target, a taken guess is useless
    assign pred_taken = btb_hit_i && pht_taken_i;

    assign lookup_seq_pc  = lookup_i.pc + pc_t'(4);
    assign resolve_seq_pc = resolve_i.pc + pc_t'(4);

    // Repair of an older branch beats any new prediction
    always_comb begin
        if (mispredict && resolve_i.taken) begin
            next_src = SRC_FIX_TARGET;
        end else if (mispredict) begin
            next_src = SRC_FIX_SEQ;
        end else if (pred_taken) begin
            next_src = SRC_PRED_TARGET;
        end else begin
            next_src = SRC_SEQ;
        end
    end

    always_comb begin
        case (next_src)
            SRC_FIX_TARGET:  next_pc_o = resolve_i.target;
            SRC_FIX_SEQ:     next_pc_o = resolve_seq_pc;
            SRC_PRED_TARGET: next_pc_o = btb_target_i;
            default:         next_pc_o = lookup_seq_pc;
        endcase
    end

    // Snapshot is the history used to index this lookup
    always_comb begin
        pred_o.btb_hit = btb_hit_i;
        pred_o.taken   = pred_taken;
        pred_o.target  = btb_target_i;
        pred_o.ghr     = ghr_i;
    end

endmodule

`default_nettype wire

// File: source/gshare_macros.svh
`ifndef GSHARE_MACROS_SVH
`define GSHARE_MACROS_SVH

// Fetch address width
`define GS_PC_WIDTH     32

// BTB index bits, taken from PC bits above the byte offset
`define GS_INDEX_WIDTH  6

// Global history length, also the pattern table index width
`define GS_HIST_WIDTH   6

// BTB tag is whatever is left above the index
`define GS_TAG_WIDTH    (`GS_PC_WIDTH - `GS_INDEX_WIDTH - 2)

// Saturating direction counters
`define GS_CTR_WIDTH    2
`define GS_CTR_INIT     2'b01

// History contents after reset
`define GS_HIST_INIT    {`GS_HIST_WIDTH{1'b0}}

`endif

// File: source/gshare_pkg.sv
`default_nettype none

`include "gshare_macros.svh"

package gshare_pkg;

    // Basic field types
    typedef logic [`GS_PC_WIDTH-1:0]    pc_t;
    typedef logic [`GS_HIST_WIDTH-1:0]  hist_t;
    typedef logic [`GS_CTR_WIDTH-1:0]   ctr_t;
    typedef logic [`GS_INDEX_WIDTH-1:0] btb_idx_t;
    typedef logic [`GS_TAG_WIDTH-1:0]   btb_tag_t;

    // Fetch request
    typedef struct packed {
        logic valid;
        pc_t  pc;
    } lookup_t;

    // Prediction returned to fetch, ghr travels down the pipe with the instruction
    typedef struct packed {
        logic  btb_hit;
        logic  taken;
        pc_t   target;
        hist_t ghr;
    } pred_t;

    // Resolved control transfer from EX/MEM
    typedef struct packed {
        logic  valid;
        pc_t   pc;
        pc_t   target;
        logic  taken;
        logic  pred_taken;
        hist_t ghr;
    } resolve_t;

    // Where the next fetch address comes from
    typedef enum logic [1:0] {
        SRC_SEQ,
        SRC_PRED_TARGET,
        SRC_FIX_SEQ,
        SRC_FIX_TARGET
    } next_pc_src_e;

endpackage

`default_nettype wire

// File: source/gshare_predictor.sv
`timescale 1ns/10ps
`default_nettype none

module gshare_predictor import gshare_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  wire lookup_t  lookup_i,
    input  wire resolve_t resolve_i,

    output pred_t         pred_o,
    output pc_t           next_pc_o,
    output logic          flush_o
);

    hist_t ghr;
    hist_t lookup_idx;
    hist_t update_idx;
    logic  pht_taken;
    logic  btb_hit;
    pc_t   btb_target;
    logic  hist_we;
    logic  pht_we;
    logic  btb_we;

    // Global history and index hashing
    history_reg i_history_reg (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .hist_we_i       (hist_we),
        .lookup_pc_i     (lookup_i.pc),
        .resolve_pc_i    (resolve_i.pc),
        .resolve_ghr_i   (resolve_i.ghr),
        .resolve_taken_i (resolve_i.taken),
        .ghr_o           (ghr),
        .lookup_idx_o    (lookup_idx),
        .update_idx_o    (update_idx)
    );

    // Direction counters
    pattern_table i_pattern_table (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .rd_idx_i     (lookup_idx),
        .wr_idx_i     (update_idx),
        .pht_we_i     (pht_we),
        .taken_i      (resolve_i.taken),
        .pred_taken_o (pht_taken)
    );

    // Targets, indexed by plain PC bits
    target_buffer i_target_buffer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rd_pc_i     (lookup_i.pc),
        .wr_pc_i     (resolve_i.pc),
        .wr_target_i (resolve_i.target),
        .btb_we_i    (btb_we),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    fetch_steer_ctrl i_fetch_steer_ctrl (
        .lookup_i     (lookup_i),
        .resolve_i    (resolve_i),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .pht_taken_i  (pht_taken),
        .ghr_i        (ghr),
        .pred_o       (pred_o),
        .next_pc_o    (next_pc_o),
        .flush_o      (flush_o),
        .hist_we_o    (hist_we),
        .pht_we_o     (pht_we),
        .btb_we_o     (btb_we)
    );

endmodule

`default_nettype wire

// File: source/history_reg.sv
`timescale 1ns/10ps
`default_nettype none

`include "gshare_macros.svh"

module history_reg import gshare_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    input  wire logic  hist_we_i,
    input  wire pc_t   lookup_pc_i,
    input  wire pc_t   resolve_pc_i,
    input  wire hist_t resolve_ghr_i,
    input  wire logic  resolve_taken_i,

    output hist_t      ghr_o,
    output hist_t      lookup_idx_o,
    output hist_t      update_idx_o
);

    hist_t ghr_q;

    // Rebuilt from the snapshot so wrong-path updates never linger
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ghr_q <= `GS_HIST_INIT;
        end else if (hist_we_i) begin
            ghr_q <= {resolve_ghr_i[`GS_HIST_WIDTH-2:0], resolve_taken_i};
        end
    end

    assign ghr_o = ghr_q;

    // gshare hash, word-aligned PC bits xor history
    assign lookup_idx_o = lookup_pc_i[`GS_HIST_WIDTH+1:2] ^ ghr_q;

    // Update uses the history seen at fetch time, not the current one
    assign update_idx_o = resolve_pc_i[`GS_HIST_WIDTH+1:2] ^ resolve_ghr_i;

endmodule

`default_nettype wire

// File: source/pattern_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "gshare_macros.svh"

module pattern_table import gshare_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    input  wire hist_t rd_idx_i,
    input  wire hist_t wr_idx_i,
    input  wire logic  pht_we_i,
    input  wire logic  taken_i,

    output logic       pred_taken_o
);

    localparam int   PHT_DEPTH = 1 << `GS_HIST_WIDTH;
    localparam ctr_t CTR_MAX   = '1;
    localparam ctr_t CTR_MIN   = '0;

    ctr_t ctr_q [PHT_DEPTH];
    ctr_t ctr_cur;
    ctr_t ctr_next;

    assign ctr_cur = ctr_q[wr_idx_i];

    // Two-bit saturating step
    always_comb begin
        ctr_next = ctr_cur;
        if (taken_i) begin
            if (ctr_cur != CTR_MAX) begin
                ctr_next = ctr_cur + 1'b1;
            end
        end else begin
            if (ctr_cur != CTR_MIN) begin
                ctr_next = ctr_cur - 1'b1;
            end
        end
    end

    // All counters start weakly not taken
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                ctr_q[i] <= `GS_CTR_INIT;
            end
        end else if (pht_we_i) begin
            ctr_q[wr_idx_i] <= ctr_next;
        end
    end

    // Direction is the counter MSB
    assign pred_taken_o = ctr_q[rd_idx_i][`GS_CTR_WIDTH-1];

endmodule

`default_nettype wire

// File: source/target_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "gshare_macros.svh"

module target_buffer import gshare_pkg::*; (
    input  wire logic clk_i,
    input  wire logic rst_ni,
    input  wire pc_t  rd_pc_i,
    input  wire pc_t  wr_pc_i,
    input  wire pc_t  wr_target_i,
    input  wire logic btb_we_i,

    output logic      hit_o,
    output pc_t       target_o
);

    localparam int BTB_DEPTH = 1 << `GS_INDEX_WIDTH;

    logic [BTB_DEPTH-1:0] valid_q;
    btb_tag_t             tag_q    [BTB_DEPTH];
    pc_t                  target_q [BTB_DEPTH];

    btb_idx_t rd_idx;
    btb_idx_t wr_idx;
    btb_tag_t rd_tag;
    btb_tag_t wr_tag;

    // Direct mapped, index sits just above the byte offset
    assign rd_idx = rd_pc_i[`GS_INDEX_WIDTH+1:2];
    assign rd_tag = rd_pc_i[`GS_PC_WIDTH-1:`GS_INDEX_WIDTH+2];
    assign wr_idx = wr_pc_i[`GS_INDEX_WIDTH+1:2];
    assign wr_tag = wr_pc_i[`GS_PC_WIDTH-1:`GS_INDEX_WIDTH+2];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (btb_we_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag and target payload
    always_ff @(posedge clk_i) begin
        if (btb_we_i) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target_i;
        end
    end

    // Targets are fixed per PC, so a tag match is all that is needed
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

endmodule

`default_nettype wire

// File: tb/gshare_vectors.svh
`ifndef GSHARE_VECTORS_SVH
`define GSHARE_VECTORS_SVH

// Columns: lookup valid, lookup pc, resolve valid, resolve pc, resolve target,
// actual taken, copy (1 = pred_taken and ghr from last lookup of that pc), pred_taken, ghr
task automatic build_vector_table();
    // Fresh after reset, nothing hits
    add_step(1, 32'h0000_1000, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);
    add_step(1, 32'h0000_1010, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);
    add_step(1, 32'h0000_1020, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);

    // Not-taken resolve must leave the BTB empty
    add_step(0, 32'h0000_0000, 1, 32'h0000_1010, 32'h0000_2400, 0, 1, 0, 6'h00);
    add_step(1, 32'h0000_1010, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);

    // First taken resolve fills the BTB and mispredicts
    add_step(1, 32'h0000_1000, 1, 32'h0000_1000, 32'h0000_2000, 1, 1, 0, 6'h00);
    add_step(1, 32'h0000_1000, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);

    // Saturate A at snapshot 0, then one not-taken
    add_step(1, 32'h0000_1000, 1, 32'h0000_1000, 32'h0000_2000, 1, 0, 0, 6'h00);
    add_step(1, 32'h0000_1000, 1, 32'h0000_1000, 32'h0000_2000, 1, 0, 1, 6'h00);
    add_step(1, 32'h0000_1000, 1, 32'h0000_1000, 32'h0000_2000, 0, 0, 1, 6'h00);
    add_step(1, 32'h0000_1000, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);

    // C trained down at snapshot 3f, then needs two taken to flip
    add_step(0, 32'h0000_0000, 1, 32'h0000_1020, 32'h0000_2800, 1, 0, 0, 6'h3f);
    add_step(0, 32'h0000_0000, 1, 32'h0000_1020, 32'h0000_2800, 0, 0, 0, 6'h3f);
    add_step(0, 32'h0000_0000, 1, 32'h0000_1020, 32'h0000_2800, 0, 0, 0, 6'h3f);
    add_step(0, 32'h0000_0000, 1, 32'h0000_1020, 32'h0000_2800, 0, 0, 0, 6'h3f);
    add_step(1, 32'h0000_1020, 1, 32'h0000_1020, 32'h0000_2800, 1, 0, 0, 6'h3f);
    add_step(1, 32'h0000_1020, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);
    add_step(1, 32'h0000_1020, 1, 32'h0000_1020, 32'h0000_2800, 1, 0, 0, 6'h3f);
    add_step(1, 32'h0000_1020, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);

    // Redirect from a resolve beats a predicted-taken lookup
    add_step(1, 32'h0000_1020, 1, 32'h0000_1000, 32'h0000_2000, 1, 0, 0, 6'h3f);
    add_step(1, 32'h0000_1020, 1, 32'h0000_1010, 32'h0000_2400, 0, 0, 1, 6'h3f);

    // History chain through copied snapshots
    add_step(1, 32'h0000_1000, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);
    add_step(1, 32'h0000_1010, 1, 32'h0000_1000, 32'h0000_2000, 1, 1, 0, 6'h00);
    add_step(1, 32'h0000_1020, 1, 32'h0000_1010, 32'h0000_2400, 0, 1, 0, 6'h00);
    add_step(1, 32'h0000_1000, 1, 32'h0000_1020, 32'h0000_2800, 1, 1, 0, 6'h00);
    add_step(1, 32'h0000_1010, 1, 32'h0000_1000, 32'h0000_2000, 0, 1, 0, 6'h00);
    add_step(1, 32'h0000_1020, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);

    // E shares A's BTB slot with a different tag
    add_step(0, 32'h0000_0000, 1, 32'h0000_5000, 32'h0000_6000, 1, 0, 0, 6'h00);
    add_step(1, 32'h0000_1000, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);
    add_step(1, 32'h0000_5000, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);
    add_step(1, 32'h0000_1000, 1, 32'h0000_1000, 32'h0000_2000, 1, 0, 0, 6'h05);
    add_step(1, 32'h0000_5000, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);
    add_step(1, 32'h0000_1000, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);
    add_step(0, 32'h0000_0000, 0, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, 6'h00);
endtask

`endif

// File: tb/gshare_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "gshare_macros.svh"

module gshare_tb import gshare_pkg::*; ();

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 8;
    localparam int RANDOM_STEPS   = 200;
    localparam int TIMEOUT_MARGIN = 50;
    localparam int HW             = `GS_HIST_WIDTH;

    typedef struct packed {
        logic  lk_valid;
        pc_t   lk_pc;
        logic  rs_valid;
        pc_t   rs_pc;
        pc_t   rs_target;
        logic  rs_taken;
        logic  rs_copy;
        logic  rs_pred_taken;
        hist_t rs_ghr;
    } step_t;

    logic     clk_i;
    logic     rst_ni;
    lookup_t  lookup;
    resolve_t resolve;
    pred_t    pred;
    pc_t      next_pc;
    logic     flush;

    // Reference model state
    ctr_t     m_ctr        [1 << `GS_HIST_WIDTH];
    logic     m_btb_valid  [1 << `GS_INDEX_WIDTH];
    btb_tag_t m_btb_tag    [1 << `GS_INDEX_WIDTH];
    pc_t      m_btb_target [1 << `GS_INDEX_WIDTH];
    hist_t    m_ghr;

    // Last prediction per pc, taken bit on top of the snapshot
    logic [HW:0] last_pred [pc_t];

    step_t       steps [$];
    step_t       rnd_step;
    pc_t         pc_pool [8];
    logic [31:0] seed;
    int          pool_sel;
    int          errors      = 0;
    int          checks      = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    gshare_predictor i_dut (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .lookup_i  (lookup),
        .resolve_i (resolve),
        .pred_o    (pred),
        .next_pc_o (next_pc),
        .flush_o   (flush)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_step(input logic lv, input pc_t lpc, input logic rv, input pc_t rpc,
                            input pc_t rtgt, input logic rtk, input logic cp,
                            input logic ptk, input hist_t rghr);
        step_t s;
        s.lk_valid      = lv;
        s.lk_pc         = lpc;
        s.rs_valid      = rv;
        s.rs_pc         = rpc;
        s.rs_target     = rtgt;
        s.rs_taken      = rtk;
        s.rs_copy       = cp;
        s.rs_pred_taken = ptk;
        s.rs_ghr        = rghr;
        steps.push_back(s);
    endtask

    `include "gshare_vectors.svh"

    task automatic compare_value(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, exp_val, act_val);
        end
    endtask

    task automatic check_outputs(input step_t s, input resolve_t rs);
        btb_idx_t bidx;
        hist_t    pidx;
        logic     exp_hit;
        logic     exp_taken;
        logic     exp_flush;
        pc_t      exp_next;
        bidx      = s.lk_pc[`GS_INDEX_WIDTH+1:2];
        pidx      = s.lk_pc[`GS_HIST_WIDTH+1:2] ^ m_ghr;
        exp_hit   = m_btb_valid[bidx] &&
                    (m_btb_tag[bidx] == s.lk_pc[`GS_PC_WIDTH-1:`GS_INDEX_WIDTH+2]);
        exp_taken = exp_hit && m_ctr[pidx][1];
        exp_flush = rs.valid && (rs.taken != rs.pred_taken);
        if (exp_flush && rs.taken) begin
            exp_next = rs.target;
        end else if (exp_flush) begin
            exp_next = rs.pc + 4;
        end else if (exp_taken) begin
            exp_next = m_btb_target[bidx];
        end else begin
            exp_next = s.lk_pc + 4;
        end
        compare_value("flush_o", exp_flush, flush);
        if (s.lk_valid || exp_flush) begin
            compare_value("next_pc_o", exp_next, next_pc);
        end
        if (s.lk_valid) begin
            compare_value("pred_o.btb_hit", exp_hit, pred.btb_hit);
            compare_value("pred_o.taken", exp_taken, pred.taken);
            compare_value("pred_o.ghr", m_ghr, pred.ghr);
            if (exp_hit) begin
                compare_value("pred_o.target", m_btb_target[bidx], pred.target);
            end
            last_pred[s.lk_pc] = {exp_taken, m_ghr};
        end
    endtask

    // Mirrors what the tables hold after the coming rising edge
    task automatic update_model(input resolve_t rs);
        hist_t    widx;
        btb_idx_t bidx;
        widx = rs.pc[`GS_HIST_WIDTH+1:2] ^ rs.ghr;
        bidx = rs.pc[`GS_INDEX_WIDTH+1:2];
        if (rs.valid) begin
            if (rs.taken && m_ctr[widx] != 2'b11) begin
                m_ctr[widx] = m_ctr[widx] + 1;
            end else if (!rs.taken && m_ctr[widx] != 2'b00) begin
                m_ctr[widx] = m_ctr[widx] - 1;
            end
            m_ghr = {rs.ghr[HW-2:0], rs.taken};
            if (rs.taken) begin
                m_btb_valid[bidx]  = 1'b1;
                m_btb_tag[bidx]    = rs.pc[`GS_PC_WIDTH-1:`GS_INDEX_WIDTH+2];
                m_btb_target[bidx] = rs.target;
            end
        end
    endtask

    task automatic run_step(input step_t s);
        resolve_t    rs;
        logic [HW:0] rec;
        @(negedge clk_i);
        rs.valid  = s.rs_valid;
        rs.pc     = s.rs_pc;
        rs.target = s.rs_target;
        rs.taken  = s.rs_taken;
        if (s.rs_copy) begin
            rec = '0;
            if (last_pred.exists(s.rs_pc)) begin
                rec = last_pred[s.rs_pc];
            end
            rs.pred_taken = rec[HW];
            rs.ghr        = rec[HW-1:0];
        end else begin
            rs.pred_taken = s.rs_pred_taken;
            rs.ghr        = s.rs_ghr;
        end
        lookup.valid = s.lk_valid;
        lookup.pc    = s.lk_pc;
        resolve      = rs;
        // Sample shortly before the rising edge
        #(CLK_PERIOD/2 - 10);
        check_outputs(s, rs);
        update_model(rs);
    endtask

    initial begin
        clk_i   = 1'b0;
        rst_ni  = 1'b0;
        lookup  = '0;
        resolve = '0;
        seed    = 32'hf1f2836a;
        m_ghr   = '0;
        for (int i = 0; i < (1 << `GS_HIST_WIDTH); i++) begin
            m_ctr[i] = `GS_CTR_INIT;
        end
        for (int i = 0; i < (1 << `GS_INDEX_WIDTH); i++) begin
            m_btb_valid[i] = 1'b0;
        end
        // Pairs share a BTB slot with different tags
        pc_pool = '{32'h0000_3000, 32'h0000_4000, 32'h0000_3010, 32'h0000_5010,
                    32'h0000_30fc, 32'h0000_3024, 32'h0000_7024, 32'h0000_3008};
        build_vector_table();
        cycle_limit = RESET_CYCLES + steps.size() + RANDOM_STEPS + TIMEOUT_MARGIN;

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        foreach (steps[i]) begin
            run_step(steps[i]);
        end

        // Random phase, each pc keeps one fixed target
        for (int n = 0; n < RANDOM_STEPS; n++) begin
            seed                   = xorshift32(seed);
            rnd_step.lk_valid      = seed[0] | seed[1];
            rnd_step.lk_pc         = pc_pool[seed[4:2]];
            rnd_step.rs_valid      = seed[5] | seed[6];
            pool_sel               = seed[9:7];
            rnd_step.rs_pc         = pc_pool[pool_sel];
            rnd_step.rs_target     = pc_pool[pool_sel] + 32'h0000_0800;
            rnd_step.rs_taken      = seed[10];
            rnd_step.rs_copy       = 1'b1;
            rnd_step.rs_pred_taken = 1'b0;
            rnd_step.rs_ghr        = '0;
            run_step(rnd_step);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
